//--- src/mmu_pkg.sv
// Sv32 MMU package: widths, PTE flag indices, privilege codes, typedefs, walker states
package mmu_pkg;

  // ============================================================
  // Address and page table types
  // ============================================================

  typedef logic [31:0] vaddr_t;      // Virtual address
  typedef logic [31:0] paddr_t;      // Physical address, low 32 bits only
  typedef logic [19:0] vpn_t;        // Full VPN, vaddr[31:12]
  typedef logic [9:0]  vpn_part_t;   // One level index, VPN[1] or VPN[0]
  typedef logic [21:0] ppn_t;        // PPN as stored in pte[31:10]
  typedef logic [31:0] pte_t;        // Raw Sv32 PTE
  typedef logic [7:0]  pte_flags_t;  // D A G U X W R V

  // Privilege mode as seen by the MMU
  typedef logic [1:0] priv_t;

  // ============================================================
  // Constants
  // ============================================================

  localparam int unsigned page_shift  = 12;  // 4 KiB pages
  localparam int unsigned tlb_entries = 16;

  typedef logic [3:0] tlb_idx_t;  // Sized for tlb_entries

  // Flag bit positions inside the PTE
  localparam int unsigned pte_v = 0;  // Valid
  localparam int unsigned pte_r = 1;  // Readable
  localparam int unsigned pte_w = 2;  // Writable
  localparam int unsigned pte_x = 3;  // Executable
  localparam int unsigned pte_u = 4;  // User page

  // Encodings 1 and 2 both count as supervisor
  localparam priv_t priv_user    = 2'd0;
  localparam priv_t priv_machine = 2'd3;

  // ============================================================
  // Walker FSM
  // ============================================================

  typedef enum logic [2:0] {
    idle,     // Waiting for a request
    walk_l1,  // Fetching the level 1 PTE
    walk_l0,  // Fetching the level 0 PTE
    fill,     // Writing the TLB, answering
    fault     // Answering with a page fault
  } ptw_state_t;

endpackage

//--- src/tlb_if.sv
// TLB interface: walker-side lookup and fill signals with walker and tlb modports
interface tlb_if;

  // Lookup, answered combinationally by the TLB
  mmu_pkg::vpn_t       lookup_vpn;
  logic                hit;        // Some valid entry matches
  mmu_pkg::ppn_t       hit_ppn;
  mmu_pkg::pte_flags_t hit_flags;

  // Fill, one-cycle pulse from the walker
  logic                fill;
  mmu_pkg::vpn_t       fill_vpn;
  mmu_pkg::ppn_t       fill_ppn;
  mmu_pkg::pte_flags_t fill_flags;

  // Walker side
  modport walker (
    output lookup_vpn,
    input  hit, hit_ppn, hit_flags,
    output fill, fill_vpn, fill_ppn, fill_flags
  );

  // TLB side
  modport tlb (
    input  lookup_vpn,
    output hit, hit_ppn, hit_flags,
    input  fill, fill_vpn, fill_ppn, fill_flags
  );

endinterface

//--- src/pte_check.sv
// PTE permission check: flag sanity, privilege, SUM, MXR and access type
module pte_check (
  input  mmu_pkg::pte_flags_t flags,
  input  logic                is_store,
  input  logic                is_fetch,
  input  logic                sum,       // Supervisor may touch user pages
  input  logic                mxr,       // Executable pages readable
  input  mmu_pkg::priv_t      priv,
  output logic                allow
);

  logic flag_ok;    // Well-formed leaf
  logic priv_ok;    // Privilege against U bit
  logic access_ok;  // Load, store or fetch right

  always_comb begin
    // V set, some of R/W/X set, and no W-only encoding
    flag_ok = flags[mmu_pkg::pte_v] &&
              (flags[mmu_pkg::pte_r] || flags[mmu_pkg::pte_w] || flags[mmu_pkg::pte_x]) &&
              !(flags[mmu_pkg::pte_w] && !flags[mmu_pkg::pte_r]);

    // ============================================================
    // Privilege
    // ============================================================
    if (priv == mmu_pkg::priv_user) begin
      priv_ok = flags[mmu_pkg::pte_u];  // User needs a user page
    end else if (priv == mmu_pkg::priv_machine) begin
      priv_ok = 1'b1;  // Machine mode is never translated
    end else begin
      // Supervisor on a user page only with SUM
      priv_ok = !flags[mmu_pkg::pte_u] || sum;
    end

    // ============================================================
    // Access type
    // ============================================================
    if (is_fetch) begin
      access_ok = flags[mmu_pkg::pte_x];
    end else if (is_store) begin
      access_ok = flags[mmu_pkg::pte_w];
    end else begin
      access_ok = flags[mmu_pkg::pte_r] || (flags[mmu_pkg::pte_x] && mxr);  // Load
    end

    allow = flag_ok && priv_ok && access_ok;
  end

endmodule

//--- src/tlb.sv
// Fully associative TLB: parallel lookup, full and per-VPN flush, round-robin fill
module tlb (
  input  logic          clk,
  input  logic          reset_n,
  tlb_if.tlb            bus,
  input  logic          flush_all,    // Invalidate every entry
  input  logic          flush_vaddr,  // Invalidate entries matching flush_vpn
  input  mmu_pkg::vpn_t flush_vpn
);

  // ============================================================
  // Entry storage
  // ============================================================

  logic [mmu_pkg::tlb_entries-1:0] valid_q;  // Per-entry valid
  mmu_pkg::vpn_t       vpn_q   [mmu_pkg::tlb_entries];
  mmu_pkg::ppn_t       ppn_q   [mmu_pkg::tlb_entries];
  mmu_pkg::pte_flags_t flags_q [mmu_pkg::tlb_entries];

  mmu_pkg::tlb_idx_t rr_ptr;  // Next victim

  logic [mmu_pkg::tlb_entries-1:0] match;  // Lookup compare per entry

  // ============================================================
  // Lookup
  // ============================================================

  always_comb begin
    bus.hit_ppn   = '0;
    bus.hit_flags = '0;
    for (int i = 0; i < mmu_pkg::tlb_entries; i++) begin
      match[i] = valid_q[i] && (vpn_q[i] == bus.lookup_vpn);
      if (match[i]) begin
        bus.hit_ppn   = bus.hit_ppn | ppn_q[i];      // OR mux, at most one match
        bus.hit_flags = bus.hit_flags | flags_q[i];
      end
    end
  end

  assign bus.hit = |match;

  // ============================================================
  // Valid bits and replacement pointer
  // ============================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      valid_q <= '0;
      rr_ptr  <= '0;
    end else begin
      if (flush_all) begin
        valid_q <= '0;
      end else if (flush_vaddr) begin
        for (int i = 0; i < mmu_pkg::tlb_entries; i++) begin
          if (vpn_q[i] == flush_vpn) begin
            valid_q[i] <= 1'b0;
          end
        end
      end
      // Fill comes last so a same-cycle flush spares the new entry
      if (bus.fill) begin
        valid_q[rr_ptr] <= 1'b1;
        rr_ptr          <= rr_ptr + 1'b1;  // Wraps at 16
      end
    end
  end

  // Entry contents, written only on fill
  always_ff @(posedge clk) begin
    if (bus.fill) begin
      vpn_q[rr_ptr]   <= bus.fill_vpn;
      ppn_q[rr_ptr]   <= bus.fill_ppn;
      flags_q[rr_ptr] <= bus.fill_flags;
    end
  end

  // Walker fills only after a miss, so no VPN is ever cached twice
  a_single_match: assert property (
    @(posedge clk) disable iff (!reset_n) $onehot0(match)
  ) else $error("tlb: more than one entry matches lookup_vpn");

endmodule

//--- src/ptw.sv
// Sv32 walker FSM: bare, TLB hit and miss handling, two-level page table walk
module ptw (
  input  logic                clk,
  input  logic                reset_n,
  // Translation request
  input  logic                req_valid,
  input  mmu_pkg::vaddr_t     req_vaddr,
  input  logic                req_is_store,
  input  logic                req_is_fetch,
  output logic                req_ready,       // One-cycle completion pulse
  output mmu_pkg::paddr_t     req_paddr,
  output logic                req_page_fault,  // Qualified by req_ready
  // CSR state
  input  logic [31:0]         satp,
  input  mmu_pkg::priv_t      priv_mode,
  input  logic                mstatus_sum,
  input  logic                mstatus_mxr,
  // Page table memory
  output logic                mem_req_valid,   // Held until mem_resp_valid
  output mmu_pkg::paddr_t     mem_req_addr,
  input  logic                mem_resp_valid,
  input  mmu_pkg::pte_t       mem_resp_data,
  tlb_if.walker               bus
);

  mmu_pkg::ptw_state_t state;

  // Request captured at acceptance
  mmu_pkg::vaddr_t     vaddr_q;
  logic                is_store_q;
  logic                is_fetch_q;
  // Leaf PTE from level 0
  mmu_pkg::ppn_t       leaf_ppn_q;
  mmu_pkg::pte_flags_t leaf_flags_q;

  logic                xlate_on;    // Sv32 active, not machine mode
  logic                accept;      // Request taken this cycle
  logic                resp;        // PTE arrives this cycle
  mmu_pkg::ppn_t       resp_ppn;
  mmu_pkg::pte_flags_t resp_flags;
  logic                resp_nonleaf;  // Valid pointer PTE
  logic                hit_allow;
  logic                walk_allow;

  // PTE address: ppn * 4096 + index * 4, truncated to 32 bits
  function automatic mmu_pkg::paddr_t pte_addr(mmu_pkg::ppn_t base, mmu_pkg::vpn_part_t idx);
    logic [33:0] full;
    full = ({12'b0, base} << mmu_pkg::page_shift) + {22'b0, idx, 2'b00};
    return full[31:0];
  endfunction

  // ============================================================
  // Decode
  // ============================================================

  assign xlate_on = satp[31] && (priv_mode != mmu_pkg::priv_machine);
  assign accept   = (state == mmu_pkg::idle) && req_valid && !req_ready;
  assign resp     = mem_req_valid && mem_resp_valid;

  assign resp_ppn     = mem_resp_data[31:10];
  assign resp_flags   = mem_resp_data[7:0];
  assign resp_nonleaf = resp_flags[mmu_pkg::pte_v] && !resp_flags[mmu_pkg::pte_r] &&
                        !resp_flags[mmu_pkg::pte_w] && !resp_flags[mmu_pkg::pte_x];

  assign bus.lookup_vpn = req_vaddr[31:12];  // Held by requester until req_ready

  // Cached entry against the current access
  pte_check u_hit_check (
    .flags    (bus.hit_flags),
    .is_store (req_is_store),
    .is_fetch (req_is_fetch),
    .sum      (mstatus_sum),
    .mxr      (mstatus_mxr),
    .priv     (priv_mode),
    .allow    (hit_allow)
  );

  // Fetched leaf against the captured access
  pte_check u_walk_check (
    .flags    (resp_flags),
    .is_store (is_store_q),
    .is_fetch (is_fetch_q),
    .sum      (mstatus_sum),
    .mxr      (mstatus_mxr),
    .priv     (priv_mode),
    .allow    (walk_allow)
  );

  // TLB write during fill, one cycle
  assign bus.fill       = (state == mmu_pkg::fill);
  assign bus.fill_vpn   = vaddr_q[31:12];
  assign bus.fill_ppn   = leaf_ppn_q;
  assign bus.fill_flags = leaf_flags_q;

  // ============================================================
  // Control FSM
  // ============================================================

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state          <= mmu_pkg::idle;
      req_ready      <= 1'b0;
      req_page_fault <= 1'b0;
      mem_req_valid  <= 1'b0;
    end else begin
      req_ready      <= 1'b0;  // Pulses only
      req_page_fault <= 1'b0;
      case (state)
        mmu_pkg::idle: begin
          if (accept) begin
            if (!xlate_on) begin
              req_ready <= 1'b1;  // Bare, PA = VA
            end else if (bus.hit) begin
              req_ready      <= 1'b1;
              req_page_fault <= !hit_allow;
            end else begin
              mem_req_valid <= 1'b1;  // Level 1 fetch
              state         <= mmu_pkg::walk_l1;
            end
          end
        end
        mmu_pkg::walk_l1: begin
          if (resp) begin
            mem_req_valid <= 1'b0;
            // Superpage leaves and bad PTEs both fault here
            state <= resp_nonleaf ? mmu_pkg::walk_l0 : mmu_pkg::fault;
          end
        end
        mmu_pkg::walk_l0: begin
          if (!mem_req_valid) begin
            mem_req_valid <= 1'b1;  // Address set at the L1 response
          end else if (resp) begin
            mem_req_valid <= 1'b0;
            state         <= walk_allow ? mmu_pkg::fill : mmu_pkg::fault;
          end
        end
        mmu_pkg::fill: begin
          req_ready <= 1'b1;
          state     <= mmu_pkg::idle;
        end
        mmu_pkg::fault: begin
          req_ready      <= 1'b1;
          req_page_fault <= 1'b1;
          state          <= mmu_pkg::idle;
        end
        default: state <= mmu_pkg::idle;
      endcase
    end
  end

  // ============================================================
  // Datapath
  // ============================================================

  always_ff @(posedge clk) begin
    if (accept) begin
      vaddr_q      <= req_vaddr;
      is_store_q   <= req_is_store;
      is_fetch_q   <= req_is_fetch;
      req_paddr    <= xlate_on ? {bus.hit_ppn[19:0], req_vaddr[11:0]} : req_vaddr;
      mem_req_addr <= pte_addr(satp[21:0], req_vaddr[31:22]);  // satp.ppn, VPN[1]
    end
    if (state == mmu_pkg::walk_l1 && resp) begin
      mem_req_addr <= pte_addr(resp_ppn, vaddr_q[21:12]);  // Next table, VPN[0]
    end
    if (state == mmu_pkg::walk_l0 && resp) begin
      leaf_ppn_q   <= resp_ppn;
      leaf_flags_q <= resp_flags;
    end
    if (state == mmu_pkg::fill) begin
      req_paddr <= {leaf_ppn_q[19:0], vaddr_q[11:0]};
    end
  end

  // Memory side sees a steady address for the whole request
  a_addr_stable: assert property (
    @(posedge clk) disable iff (!reset_n)
    (mem_req_valid && !mem_resp_valid) |=> $stable(mem_req_addr)
  ) else $error("ptw: mem_req_addr changed while waiting");

  // Completion is a single-cycle pulse
  a_ready_pulse: assert property (
    @(posedge clk) disable iff (!reset_n) req_ready |=> !req_ready
  ) else $error("ptw: req_ready held for two cycles");

endmodule

//--- src/mmu_top.sv
// MMU top level: plain request, memory, CSR and flush ports around walker and TLB
module mmu_top (
  input  logic            clk,
  input  logic            reset_n,
  // Translation request
  input  logic            req_valid,
  input  mmu_pkg::vaddr_t req_vaddr,
  input  logic            req_is_store,
  input  logic            req_is_fetch,
  output logic            req_ready,
  output mmu_pkg::paddr_t req_paddr,
  output logic            req_page_fault,
  // Page table memory
  output logic            mem_req_valid,
  output mmu_pkg::paddr_t mem_req_addr,
  input  logic            mem_resp_valid,
  input  mmu_pkg::pte_t   mem_resp_data,
  // CSR state
  input  logic [31:0]     satp,           // Mode bit 31, root PPN 21:0
  input  mmu_pkg::priv_t  priv_mode,
  input  logic            mstatus_sum,
  input  logic            mstatus_mxr,
  // TLB maintenance
  input  logic            tlb_flush_all,
  input  logic            tlb_flush_vaddr,
  input  mmu_pkg::vaddr_t tlb_flush_addr
);

  tlb_if tlb_bus ();  // Walker to TLB

  // ============================================================
  // Walker
  // ============================================================

  ptw u_ptw (
    .clk            (clk),
    .reset_n        (reset_n),
    .req_valid      (req_valid),
    .req_vaddr      (req_vaddr),
    .req_is_store   (req_is_store),
    .req_is_fetch   (req_is_fetch),
    .req_ready      (req_ready),
    .req_paddr      (req_paddr),
    .req_page_fault (req_page_fault),
    .satp           (satp),
    .priv_mode      (priv_mode),
    .mstatus_sum    (mstatus_sum),
    .mstatus_mxr    (mstatus_mxr),
    .mem_req_valid  (mem_req_valid),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_data  (mem_resp_data),
    .bus            (tlb_bus.walker)
  );

  // TLB, flush by page number of the given address
  tlb u_tlb (
    .clk         (clk),
    .reset_n     (reset_n),
    .bus         (tlb_bus.tlb),
    .flush_all   (tlb_flush_all),
    .flush_vaddr (tlb_flush_vaddr),
    .flush_vpn   (tlb_flush_addr[31:12])
  );

endmodule

//--- test/mmu_ref_model.svh
// Reference model: sparse page table, TLB shadow, permission rule and expected translation
`ifndef MMU_REF_MODEL_SVH
`define MMU_REF_MODEL_SVH

localparam mmu_pkg::ppn_t root_ppn = 22'h00100;  // Root table at 0x0010_0000

mmu_pkg::pte_t pt_mem [mmu_pkg::paddr_t];  // Sparse page table memory

// TLB shadow, same fill order and flush effect as the DUT
bit                  sh_valid [mmu_pkg::tlb_entries];
mmu_pkg::vpn_t       sh_vpn   [mmu_pkg::tlb_entries];
mmu_pkg::ppn_t       sh_ppn   [mmu_pkg::tlb_entries];
mmu_pkg::pte_flags_t sh_flags [mmu_pkg::tlb_entries];
int unsigned         sh_ptr = 0;  // Next victim

// Table base times page size plus index times PTE size
function automatic mmu_pkg::paddr_t table_addr(mmu_pkg::ppn_t base, mmu_pkg::vpn_part_t idx);
  return {base[19:0], 12'h000} + {20'h0, idx, 2'b00};
endfunction

function automatic mmu_pkg::pte_t read_pte(mmu_pkg::paddr_t a);
  if (pt_mem.exists(a)) begin
    return pt_mem[a];
  end
  return '0;  // Unmapped words read as invalid PTEs
endfunction

// 64 pages: 8 level 1 slots, 8 spread level 0 slots each
function automatic mmu_pkg::vaddr_t page_vaddr(int unsigned p);
  mmu_pkg::vpn_part_t hi;
  mmu_pkg::vpn_part_t lo;
  hi = 10'h040 + 10'(p / 8);
  lo = 10'h010 + 10'(3 * (p % 8));
  return {hi, lo, 12'h000};
endfunction

task automatic build_page_table();
  logic [31:0]         r;
  logic [31:0]         p;
  mmu_pkg::ppn_t       l0_ppn;
  mmu_pkg::paddr_t     l1a;
  mmu_pkg::pte_flags_t fl;
  for (int i = 0; i < 8; i++) begin
    r      = next_rand();
    l0_ppn = 22'h00200 + 22'(i);
    l1a    = table_addr(root_ppn, 10'h040 + 10'(i));
    if (i >= 4 && r[2:0] == 3'd0) begin
      pt_mem[l1a] = '0;  // Invalid
    end else if (i >= 4 && r[2:0] == 3'd1) begin
      pt_mem[l1a] = {r[31:10], 2'b00, 8'h0b};  // Superpage leaf, faults
    end else if (i >= 4 && r[2:0] == 3'd2) begin
      pt_mem[l1a] = {l0_ppn, 2'b00, 8'h05};  // W without R
    end else begin
      pt_mem[l1a] = {l0_ppn, 2'b00, 8'h01};  // Pointer to level 0
    end
    for (int j = 0; j < 8; j++) begin
      r  = next_rand();
      p  = next_rand();
      fl = {r[7:5], r[4:1], 1'b1};  // Random D A G U X W R, V set
      if (r[31:28] == 4'd0) begin
        fl[mmu_pkg::pte_v] = 1'b0;
      end else if (r[31:28] == 4'd1) begin
        fl = 8'h01;  // Pointer at the last level
      end else if (r[31:28] == 4'd2) begin
        fl = 8'h15;
      end else if (fl[3:1] == 3'b000) begin
        fl[mmu_pkg::pte_r] = 1'b1;  // Keep it a leaf
      end
      pt_mem[table_addr(l0_ppn, 10'h010 + 10'(3 * j))] = {p[21:0], 2'b00, fl};
    end
  end
endtask

// Sv32 leaf rules, access type last
function automatic bit leaf_allowed(mmu_pkg::pte_flags_t f, bit st, bit fe,
                                    mmu_pkg::priv_t pv, bit sum, bit mxr);
  bit rd;
  bit wr;
  bit ex;
  bit us;
  rd = f[mmu_pkg::pte_r];
  wr = f[mmu_pkg::pte_w];
  ex = f[mmu_pkg::pte_x];
  us = f[mmu_pkg::pte_u];
  if (!f[mmu_pkg::pte_v] || {rd, wr, ex} == 3'b000 || (wr && !rd)) begin
    return 1'b0;
  end
  if (pv == mmu_pkg::priv_user && !us) begin
    return 1'b0;
  end
  if (pv != mmu_pkg::priv_user && pv != mmu_pkg::priv_machine && us && !sum) begin
    return 1'b0;  // Supervisor on user page
  end
  if (fe) begin
    return ex;
  end
  if (st) begin
    return wr;
  end
  return rd || (ex && mxr);
endfunction

function automatic int find_cached(mmu_pkg::vpn_t vpn);
  for (int i = 0; i < mmu_pkg::tlb_entries; i++) begin
    if (sh_valid[i] && sh_vpn[i] == vpn) begin
      return i;
    end
  end
  return -1;
endfunction

function automatic void record_fill(mmu_pkg::vpn_t vpn, mmu_pkg::ppn_t ppn,
                                    mmu_pkg::pte_flags_t fl);
  sh_valid[sh_ptr] = 1'b1;
  sh_vpn[sh_ptr]   = vpn;
  sh_ppn[sh_ptr]   = ppn;
  sh_flags[sh_ptr] = fl;
  sh_ptr           = (sh_ptr + 1) % mmu_pkg::tlb_entries;
endfunction

function automatic void drop_entries(bit all, mmu_pkg::vpn_t vpn);
  for (int i = 0; i < mmu_pkg::tlb_entries; i++) begin
    if (all || sh_vpn[i] == vpn) begin
      sh_valid[i] = 1'b0;
    end
  end
endfunction

// Expected outcome; kind 0 bare, 1 hit, 2 walk
task automatic predict(input mmu_pkg::vaddr_t va, input bit st, input bit fe,
                       input mmu_pkg::priv_t pv, input bit sum, input bit mxr,
                       input logic [31:0] sp, output bit fault_e,
                       output mmu_pkg::paddr_t pa, output int kind);
  int              idx;
  mmu_pkg::paddr_t a1;
  mmu_pkg::paddr_t a0;
  mmu_pkg::pte_t   pte1;
  mmu_pkg::pte_t   pte0;
  exp_addrs.delete();
  fault_e = 1'b0;
  pa      = va;
  kind    = 0;
  if (!sp[31] || pv == mmu_pkg::priv_machine) begin
    return;
  end
  idx = find_cached(va[31:12]);
  if (idx >= 0) begin
    kind    = 1;
    fault_e = !leaf_allowed(sh_flags[idx], st, fe, pv, sum, mxr);  // Rechecked per access
    pa      = {sh_ppn[idx][19:0], va[11:0]};
    return;
  end
  kind = 2;
  a1   = table_addr(sp[21:0], va[31:22]);
  exp_addrs.push_back(a1);
  pte1 = read_pte(a1);
  if (pte1[3:0] != 4'b0001) begin
    fault_e = 1'b1;  // Only a valid pointer continues
    return;
  end
  a0 = table_addr(pte1[31:10], va[21:12]);
  exp_addrs.push_back(a0);
  pte0 = read_pte(a0);
  if (!leaf_allowed(pte0[7:0], st, fe, pv, sum, mxr)) begin
    fault_e = 1'b1;
    return;
  end
  pa = {pte0[29:10], va[11:0]};
  record_fill(va[31:12], pte0[31:10], pte0[7:0]);
endtask

`endif

//--- test/mmu_tb.sv
// MMU testbench: clock, reset, xorshift stimulus, memory responder, checks and timeout
module mmu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_requests   = 400;
  localparam int max_req_cycles = 20;  // Two slow PTE reads plus flush
  localparam int timeout_cycles = num_requests * max_req_cycles + 2000;

  logic            clk;
  logic            reset_n;
  logic            req_valid;
  mmu_pkg::vaddr_t req_vaddr;
  logic            req_is_store;
  logic            req_is_fetch;
  logic            req_ready;
  mmu_pkg::paddr_t req_paddr;
  logic            req_page_fault;
  logic            mem_req_valid;
  mmu_pkg::paddr_t mem_req_addr;
  logic            mem_resp_valid = 1'b0;  // Driven by the responder only
  mmu_pkg::pte_t   mem_resp_data  = '0;
  logic [31:0]     satp;
  mmu_pkg::priv_t  priv_mode;
  logic            mstatus_sum;
  logic            mstatus_mxr;
  logic            tlb_flush_all;
  logic            tlb_flush_vaddr;
  mmu_pkg::vaddr_t tlb_flush_addr;

  logic [31:0]     rng_stim = 32'h5328_4e68;
  logic [31:0]     rng_mem  = ~32'h5328_4e68;  // Separate stream for the responder
  mmu_pkg::paddr_t seen_addrs [$];  // PTE reads answered by the responder
  mmu_pkg::paddr_t exp_addrs  [$];
  int              resp_wait = -1;
  int              n_bare  = 0;
  int              n_hit   = 0;
  int              n_walk  = 0;
  int              n_fault = 0;

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_stim = xorshift32(rng_stim);
    return rng_stim;
  endfunction

`include "mmu_ref_model.svh"

  mmu_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("Timeout: no end of the run after %0d cycles", timeout_cycles);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

  // ============================================================
  // Memory responder, 1 to 4 cycles per PTE read
  // ============================================================
  always @(posedge clk) begin
    mem_resp_valid <= 1'b0;
    if (mem_req_valid && !mem_resp_valid) begin
      if (resp_wait < 0) begin
        rng_mem   = xorshift32(rng_mem);
        resp_wait = int'(rng_mem % 4);
      end
      if (resp_wait == 0) begin
        mem_resp_valid <= 1'b1;
        mem_resp_data  <= read_pte(mem_req_addr);
        seen_addrs.push_back(mem_req_addr);
        resp_wait = -1;
      end else begin
        resp_wait--;
      end
    end
  end

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] got);
    assert (got === exp) else begin
      $display("ERROR %s expected %h actual %h", name, exp, got);
      $display("SIMULATION FAILED");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic require_seen(string what, int count);
    assert (count > 0) else begin
      $display("Coverage hole: no %s during the run", what);
      $display("SIMULATION FAILED");
      $fatal(1, "missing %s", what);
    end
  endtask

  // Half the picks from a small working set, so pages repeat
  function automatic mmu_pkg::vaddr_t pick_page(logic [31:0] r);
    return page_vaddr(r[8] ? int'(r[15:12] % 12) : int'(r[21:16]));
  endfunction

  // One-cycle flush while the walker is idle
  task automatic issue_flush();
    logic [31:0]     r;
    mmu_pkg::vaddr_t fa;
    r  = next_rand();
    fa = pick_page(r) | {20'h0, r[31:20]};
    req_valid       <= 1'b0;
    tlb_flush_all   <= (r[1:0] == 2'd0);
    tlb_flush_vaddr <= (r[1:0] != 2'd0);
    tlb_flush_addr  <= fa;
    drop_entries(r[1:0] == 2'd0, fa[31:12]);
    @(posedge clk);
    tlb_flush_all   <= 1'b0;
    tlb_flush_vaddr <= 1'b0;
  endtask

  // ============================================================
  // One request: drive, wait for req_ready, compare
  // ============================================================
  task automatic run_request(int n);
    logic [31:0]     r;
    mmu_pkg::vaddr_t va;
    mmu_pkg::priv_t  pv;
    logic [31:0]     sp;
    bit              exp_fault;
    mmu_pkg::paddr_t exp_pa;
    int              kind;
    int              cycles;
    bit              done;
    string           tag;
    va = pick_page(next_rand());
    r  = next_rand();
    va = va | {20'h0, r[11:0]};
    pv = (r[16:14] == 3'd0) ? mmu_pkg::priv_machine : (r[17] ? mmu_pkg::priv_user : 2'd1);
    sp = {(r[22:20] != 3'd0), 9'h0, root_ppn};  // Mostly Sv32 on
    predict(va, r[13:12] == 2'd1, r[13:12] == 2'd2, pv, r[18], r[19], sp,
            exp_fault, exp_pa, kind);
    seen_addrs.delete();
    req_valid    <= 1'b1;
    req_vaddr    <= va;
    req_is_store <= (r[13:12] == 2'd1);
    req_is_fetch <= (r[13:12] == 2'd2);
    satp         <= sp;
    priv_mode    <= pv;
    mstatus_sum  <= r[18];
    mstatus_mxr  <= r[19];
    cycles = 0;
    done   = 1'b0;
    while (!done) begin
      @(posedge clk);
      cycles++;
      done = req_ready;
    end
    tag = $sformatf("req %0d %s", n, (kind == 0) ? "bare" : (kind == 1) ? "hit" : "walk");
    check_value({tag, " fault"}, 32'(exp_fault), 32'(req_page_fault));
    if (!exp_fault) begin
      check_value({tag, " paddr"}, exp_pa, req_paddr);
    end
    check_value({tag, " mem reads"}, exp_addrs.size(), seen_addrs.size());
    for (int i = 0; i < exp_addrs.size(); i++) begin
      check_value({tag, " pte addr"}, exp_addrs[i], seen_addrs[i]);
    end
    if (kind != 2) begin
      check_value({tag, " latency"}, 32'd2, cycles);  // Ready one cycle after accept
    end
    n_bare  += (kind == 0);
    n_hit   += (kind == 1);
    n_walk  += (kind == 2);
    n_fault += exp_fault;
  endtask

  initial begin
    reset_n         = 1'b0;
    req_valid       = 1'b0;
    req_vaddr       = '0;
    req_is_store    = 1'b0;
    req_is_fetch    = 1'b0;
    satp            = '0;
    priv_mode       = mmu_pkg::priv_machine;
    mstatus_sum     = 1'b0;
    mstatus_mxr     = 1'b0;
    tlb_flush_all   = 1'b0;
    tlb_flush_vaddr = 1'b0;
    tlb_flush_addr  = '0;
    build_page_table();
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);
    for (int n = 0; n < num_requests; n++) begin
      if (next_rand() % 16 == 0) begin
        issue_flush();
      end
      run_request(n);
    end
    require_seen("bare translations", n_bare);
    require_seen("TLB hits", n_hit);
    require_seen("page table walks", n_walk);
    require_seen("page faults", n_fault);
    $display("Requests: %0d bare, %0d hit, %0d walk, %0d faulted", n_bare, n_hit, n_walk,
             n_fault);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- flist.f
+incdir+test
src/mmu_pkg.sv
src/tlb_if.sv
src/pte_check.sv
src/tlb.sv
src/ptw.sv
src/mmu_top.sv
test/mmu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the MMU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module mmu_tb -f flist.f -Mdir obj_dir -o Vmmu_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vmmu_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

exit 0
